// File: design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// core geometry, shared by rtl and testbench

`define CPU_WORD_W      16   // data word and register width
`define CPU_ADDR_W      10   // logical and physical address width

// paging
`define CPU_PAGE_BITS   6    // offset bits, 64 words per page
`define CPU_PAGE_COUNT  16   // physical pages in 1024 words

// register file
`define CPU_REG_COUNT   8    // registers, low 3 bits of reg field

`endif

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_top (
  input  logic                   clka,
  input  logic                   rst,
  output logic                   mem_rd,
  output logic                   mem_wr,
  output logic [`CPU_ADDR_W-1:0] mem_addr,
  output logic [`CPU_WORD_W-1:0] mem_wdata,
  input  logic [`CPU_WORD_W-1:0] mem_rdata,
  output logic                   halted,
  output logic                   fault
);
  import isa_pkg::*;
  import mem_pkg::*;

  instr_t instr;        // fetch to execute
  logic   instr_valid;
  logic   instr_done;
  logic   jump;
  laddr_t jump_target;

  mem_req_if f_req ();  // instruction side
  mem_req_if d_req ();  // data side

  fetch_unit i_fetch (
    .clka        (clka),
    .rst         (rst),
    .f_req       (f_req.requester),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_done  (instr_done),
    .jump        (jump),
    .jump_target (jump_target),
    .halted      (halted)
  );

  exec_unit i_exec (
    .clka        (clka),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_done  (instr_done),
    .jump        (jump),
    .jump_target (jump_target),
    .d_req       (d_req.requester),
    .halted      (halted)
  );

  mmu i_mmu (
    .clka      (clka),
    .rst       (rst),
    .f_req     (f_req.mmu),
    .d_req     (d_req.mmu),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .fault     (fault)
  );

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module exec_unit (
  input  logic             clka,
  input  logic             rst,
  input  isa_pkg::instr_t  instr,
  input  logic             instr_valid,
  output logic             instr_done,
  output logic             jump,
  output mem_pkg::laddr_t  jump_target,
  mem_req_if.requester     d_req,
  output logic             halted
);
  import isa_pkg::*;

  localparam int REG_BITS = $clog2(`CPU_REG_COUNT);

  core_state_e            state;
  logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];  // register file
  logic [REG_BITS-1:0]    ri;                     // selected register
  logic                   req_q;

  assign ri          = instr.reg_num[REG_BITS-1:0];       // upper reg bits ignored
  assign jump_target = instr.operand[`CPU_ADDR_W-1:0];    // low 10 bits as logical addr

  // data request fields come straight from the held instruction
  assign d_req.req   = req_q;
  assign d_req.wr    = (instr.opcode == op_reg2ram);
  assign d_req.laddr = instr.operand[`CPU_ADDR_W-1:0];
  assign d_req.wdata = regs[ri];

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= st_exec;
      instr_done <= 1'b0;
      jump       <= 1'b0;
      halted     <= 1'b0;
      req_q      <= 1'b0;
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      instr_done <= 1'b0;  // pulses
      jump       <= 1'b0;
      case (state)
        st_exec: begin
          if (instr_valid) begin
            case (instr.opcode)
              op_num2reg: begin
                regs[ri]   <= instr.operand;
                instr_done <= 1'b1;
              end
              op_reg_plus: begin
                regs[ri]   <= regs[ri] + instr.operand;  // wraps at 16 bits
                instr_done <= 1'b1;
              end
              op_reg_minus: begin
                regs[ri]   <= regs[ri] - instr.operand;
                instr_done <= 1'b1;
              end
              op_jmp: begin
                jump       <= 1'b1;  // target taken by fetch with done
                instr_done <= 1'b1;
              end
              op_ram2reg, op_reg2ram: begin
                req_q <= 1'b1;       // retire on done
                state <= st_data;
              end
              op_exit: begin
                halted     <= 1'b1;
                instr_done <= 1'b1;
                state      <= st_halt;
              end
              default: instr_done <= 1'b1;  // unknown opcode, no-op
            endcase
          end
        end
        st_data: begin
          if (d_req.done) begin
            req_q <= 1'b0;
            if (instr.opcode == op_ram2reg) regs[ri] <= d_req.rdata;
            instr_done <= 1'b1;
            state      <= st_exec;
          end
        end
        default: ;  // st_halt
      endcase
    end
  end

  // request holds its address until the mmu answers
  assert property (@(posedge clka) disable iff (!rst)
    (d_req.req && !d_req.done) |=> d_req.req && $stable(d_req.laddr));

  // once out of pages the data side stays stalled
  assert property (@(posedge clka) disable iff (!rst)
    d_req.fault |=> d_req.fault && !d_req.done);

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module fetch_unit (
  input  logic             clka,
  input  logic             rst,
  mem_req_if.requester     f_req,
  output isa_pkg::instr_t  instr,
  output logic             instr_valid,
  input  logic             instr_done,
  input  logic             jump,
  input  mem_pkg::laddr_t  jump_target,
  input  logic             halted
);
  import isa_pkg::*;
  import mem_pkg::*;

  core_state_e state;
  laddr_t      pc;     // address of word 0
  logic        req_q;  // request level

  assign f_req.req   = req_q;
  assign f_req.wr    = 1'b0;                                 // instruction reads only
  assign f_req.laddr = (state == st_fetch_lo) ? pc + 1'b1 : pc;  // word 1 follows word 0
  assign f_req.wdata = '0;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state       <= st_fetch_hi;
      pc          <= '0;
      req_q       <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;  // pulse
      case (state)
        st_fetch_hi, st_fetch_lo: begin
          if (!req_q) begin
            req_q <= 1'b1;               // fields settle with state
          end else if (f_req.done) begin
            req_q <= 1'b0;
            if (state == st_fetch_hi) begin
              state <= st_fetch_lo;
            end else begin
              instr_valid <= 1'b1;       // both words in
              pc          <= pc + 2'd2;
              state       <= st_wait;
            end
          end
        end
        st_wait: begin
          if (halted) begin
            state <= st_halt;            // exit retired, stop issuing
          end else if (instr_done) begin
            if (jump) pc <= jump_target;
            state <= st_fetch_hi;
          end
        end
        default: ;                       // st_halt, parked
      endcase
    end
  end

  // instruction register, loaded from the read data in the done cycle
  always_ff @(posedge clka) begin
    if (f_req.done && state == st_fetch_hi) begin
      instr.opcode  <= opcode_e'(f_req.rdata[15:8]);
      instr.reg_num <= f_req.rdata[7:0];
    end
    if (f_req.done && state == st_fetch_lo) begin
      instr.operand <= f_req.rdata;
    end
  end

  // the mmu answers only a pending fetch and never once out of pages
  assert property (@(posedge clka) disable iff (!rst)
    f_req.done |-> f_req.req && !f_req.fault);

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package isa_pkg;

  // opcode byte, high half of instruction word 0
  typedef enum logic [7:0] {
    op_jmp       = 8'd1,   // pc <= operand
    op_ram2reg   = 8'd2,   // reg <= mem[operand]
    op_reg2ram   = 8'd3,   // mem[operand] <= reg
    op_num2reg   = 8'd4,   // reg <= operand
    op_reg_plus  = 8'd5,   // reg += operand
    op_reg_minus = 8'd6,   // reg -= operand
    op_exit      = 8'd17   // stop the core
  } opcode_e;

  // states of fetch and execute sides
  typedef enum logic [2:0] {
    st_fetch_hi,  // reading word 0
    st_fetch_lo,  // reading word 1
    st_wait,      // instruction handed over, waiting for retire
    st_exec,      // execute side ready for next instruction
    st_data,      // data access in flight
    st_halt       // exit seen
  } core_state_e;

  typedef struct packed {
    opcode_e                opcode;   // word 0 [15:8]
    logic [7:0]             reg_num;  // word 0 [7:0]
    logic [`CPU_WORD_W-1:0] operand;  // word 1
  } instr_t;

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package mem_pkg;

  // translation engine states
  typedef enum logic [2:0] {
    mmu_idle,    // waiting for a request
    mmu_lookup,  // compare with last translation
    mmu_walk,    // one chain hop per cycle
    mmu_alloc,   // link lowest free page at chain end
    mmu_access,  // memory strobe out
    mmu_fault    // out of pages, sticky
  } mmu_state_e;

  typedef logic [$clog2(`CPU_PAGE_COUNT)-1:0] page_idx_t;  // physical or logical page
  typedef logic [`CPU_ADDR_W-1:0] laddr_t;                 // logical address
  typedef logic [`CPU_ADDR_W-1:0] paddr_t;                 // physical address, {page, offset}

endpackage

`default_nettype wire

// File: design/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

interface mem_req_if;
  import mem_pkg::*;

  logic                   req;    // level, held until done
  logic                   wr;     // 1 write, 0 read
  laddr_t                 laddr;  // logical address
  logic [`CPU_WORD_W-1:0] wdata;  // write data
  logic                   done;   // single cycle pulse
  logic [`CPU_WORD_W-1:0] rdata;  // valid with done
  logic                   fault;  // no free page left

  modport requester (output req, wr, laddr, wdata, input done, rdata, fault);

  modport mmu (input req, wr, laddr, wdata, output done, rdata, fault);

endinterface

`default_nettype wire

// File: design/mmu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module mmu (
  input  logic                   clka,
  input  logic                   rst,
  mem_req_if.mmu                 f_req,
  mem_req_if.mmu                 d_req,
  output logic                   mem_rd,
  output logic                   mem_wr,
  output mem_pkg::paddr_t        mem_addr,
  output logic [`CPU_WORD_W-1:0] mem_wdata,
  input  logic [`CPU_WORD_W-1:0] mem_rdata,
  output logic                   fault
);
  import mem_pkg::*;

  mmu_state_e                 state;
  page_idx_t                  chain [`CPU_PAGE_COUNT];  // next page of the process, self at tail
  page_idx_t                  lpage [`CPU_PAGE_COUNT];  // logical page held by each physical page
  logic [`CPU_PAGE_COUNT-1:0] used;                     // page belongs to the chain
  page_idx_t                  cache_lpage;              // last translation
  page_idx_t                  cache_ppage;
  page_idx_t                  cur;                      // walk position
  logic                       sel_d;                    // 1 data side, 0 fetch side
  logic                       done_q;

  laddr_t                     laddr;
  logic                       wr;
  logic [`CPU_WORD_W-1:0]     wdata;
  page_idx_t                  lp;
  page_idx_t                  free_page;
  logic                       free_found;
  logic                       issue;                    // translation known this cycle
  page_idx_t                  issue_page;

  // selected requester, fields are held stable until done
  assign laddr = sel_d ? d_req.laddr : f_req.laddr;
  assign wr    = sel_d ? d_req.wr : f_req.wr;
  assign wdata = sel_d ? d_req.wdata : f_req.wdata;
  assign lp    = laddr[`CPU_ADDR_W-1:`CPU_PAGE_BITS];

  assign f_req.done  = done_q & ~sel_d;
  assign d_req.done  = done_q & sel_d;
  assign f_req.rdata = mem_rdata;  // memory answers the cycle after mem_rd
  assign d_req.rdata = mem_rdata;
  assign fault       = (state == mmu_fault);
  assign f_req.fault = fault;
  assign d_req.fault = fault;

  // lowest free physical page
  always_comb begin
    free_found = 1'b0;
    free_page  = '0;
    for (int i = `CPU_PAGE_COUNT - 1; i >= 0; i--) begin
      if (!used[i]) begin
        free_found = 1'b1;
        free_page  = page_idx_t'(i);
      end
    end
  end

  always_comb begin
    issue      = 1'b0;
    issue_page = cache_ppage;
    case (state)
      mmu_lookup: issue = (lp == cache_lpage);  // hit
      mmu_walk: begin
        issue      = (lpage[cur] == lp);         // found in chain
        issue_page = cur;
      end
      mmu_alloc: begin
        issue      = free_found;
        issue_page = free_page;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state       <= mmu_idle;
      sel_d       <= 1'b0;
      done_q      <= 1'b0;
      mem_rd      <= 1'b0;
      mem_wr      <= 1'b0;
      used        <= `CPU_PAGE_COUNT'(1);  // only page 0 owned
      cache_lpage <= '0;
      cache_ppage <= '0;
      cur         <= '0;
      for (int i = 0; i < `CPU_PAGE_COUNT; i++) begin
        chain[i] <= page_idx_t'(i);         // every page its own tail
        lpage[i] <= '0;
      end
    end else begin
      mem_rd <= 1'b0;  // strobes are pulses
      mem_wr <= 1'b0;
      done_q <= 1'b0;
      if (issue) begin
        mem_rd      <= ~wr;
        mem_wr      <= wr;
        done_q      <= wr;               // write done with mem_wr
        cache_lpage <= lp;
        cache_ppage <= issue_page;
        state       <= mmu_access;
      end
      case (state)
        mmu_idle: begin
          // skip the read done cycle, the requester still holds req there
          if (!done_q && (f_req.req || d_req.req)) begin
            sel_d <= ~f_req.req;         // fetch side first
            state <= mmu_lookup;
          end
        end
        mmu_lookup: begin
          if (!issue) begin
            cur   <= '0;                 // chain starts at page 0
            state <= mmu_walk;
          end
        end
        mmu_walk: begin
          if (!issue) begin
            if (chain[cur] == cur) state <= mmu_alloc;  // tail, not mapped
            else cur <= chain[cur];
          end
        end
        mmu_alloc: begin
          if (free_found) begin
            chain[cur]       <= free_page;  // cur is the tail
            chain[free_page] <= free_page;
            lpage[free_page] <= lp;
            used[free_page]  <= 1'b1;
          end else begin
            state <= mmu_fault;
          end
        end
        mmu_access: begin
          done_q <= mem_rd;              // read data arrives next cycle
          state  <= mmu_idle;
        end
        default: ;                       // mmu_fault holds
      endcase
    end
  end

  // physical address and write data
  always_ff @(posedge clka) begin
    if (issue) begin
      mem_addr  <= {issue_page, laddr[`CPU_PAGE_BITS-1:0]};
      mem_wdata <= wdata;
    end
  end

  // strobes go out only for a held request and on a page the chain owns
  assert property (@(posedge clka) disable iff (!rst)
    (mem_rd || mem_wr) |->
      (sel_d ? d_req.req : f_req.req) && used[mem_addr[`CPU_ADDR_W-1:`CPU_PAGE_BITS]]);

  // the walk only visits pages that were taken off the free set
  assert property (@(posedge clka) disable iff (!rst)
    (state == mmu_walk) |-> used[cur] && used[chain[cur]]);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it, and decide on the log

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_cpu \
    -Mdir "$BUILD_DIR/obj" -o tb_cpu; then
  echo "verilator build failed"
  exit 1
fi

if ! "$BUILD_DIR/obj/tb_cpu" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"
grep -q '^\*\* PASS \*\*$' "$LOG" || exit 1
exit 0

// File: src.f
+incdir+design
+incdir+tb
design/isa_pkg.sv
design/mem_pkg.sv
design/mem_req_if.sv
design/fetch_unit.sv
design/exec_unit.sv
design/mmu.sv
design/cpu_top.sv
tb/tb_cpu.sv

// File: tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// instruction-set model, own memory copy and own page map

logic [`CPU_WORD_W-1:0] model_mem  [MEM_WORDS];
logic [`CPU_WORD_W-1:0] model_regs [`CPU_REG_COUNT];
logic                   map_valid  [`CPU_PAGE_COUNT];  // logical page has a frame
logic [LP_W-1:0]        map_page   [`CPU_PAGE_COUNT];  // frame of each logical page
int                     next_free;                     // frames go out in order, never freed
bit                     exp_halt;
bit                     exp_fault;
logic [`CPU_ADDR_W-1:0] exp_rd_addr [$];               // physical reads, fetch and data, in order
logic [`CPU_ADDR_W-1:0] exp_wr_addr [$];
logic [`CPU_WORD_W-1:0] exp_wr_data [$];

function automatic bit translate(input logic [`CPU_ADDR_W-1:0] la,
                                 output logic [`CPU_ADDR_W-1:0] pa);
  logic [LP_W-1:0] lp;
  lp = la[`CPU_ADDR_W-1:`CPU_PAGE_BITS];
  pa = '0;
  if (!map_valid[lp]) begin
    if (next_free >= `CPU_PAGE_COUNT) return 1'b0;  // no frame left
    map_valid[lp] = 1'b1;
    map_page[lp]  = next_free[LP_W-1:0];            // lowest free frame
    next_free++;
  end
  pa = {map_page[lp], la[`CPU_PAGE_BITS-1:0]};      // frame then offset
  return 1'b1;
endfunction

function automatic bit model_read(input logic [`CPU_ADDR_W-1:0] la,
                                  output logic [`CPU_WORD_W-1:0] data);
  logic [`CPU_ADDR_W-1:0] pa;
  data = '0;
  if (!translate(la, pa)) begin
    exp_fault = 1'b1;
    return 1'b0;
  end
  exp_rd_addr.push_back(pa);
  data = model_mem[pa];
  return 1'b1;
endfunction

function automatic void model_write(input logic [`CPU_ADDR_W-1:0] la,
                                    input logic [`CPU_WORD_W-1:0] data);
  logic [`CPU_ADDR_W-1:0] pa;
  if (!translate(la, pa)) begin
    exp_fault = 1'b1;
    return;
  end
  exp_wr_addr.push_back(pa);
  exp_wr_data.push_back(data);
  model_mem[pa] = data;
endfunction

// runs the program now in mem, fills the expected bus queues
task automatic run_model();
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_WORD_W-1:0] w0;
  logic [`CPU_WORD_W-1:0] w1;
  logic [`CPU_WORD_W-1:0] rd;
  logic [2:0]             ri;
  int                     steps;
  for (int a = 0; a < MEM_WORDS; a++) model_mem[a] = mem[a];
  for (int p = 0; p < `CPU_PAGE_COUNT; p++) begin
    map_valid[p] = (p == 0);  // logical 0 sits in frame 0 out of reset
    map_page[p]  = '0;
  end
  for (int r = 0; r < `CPU_REG_COUNT; r++) model_regs[r] = '0;
  next_free = 1;
  exp_halt  = 1'b0;
  exp_fault = 1'b0;
  exp_rd_addr.delete();
  exp_wr_addr.delete();
  exp_wr_data.delete();
  pc    = '0;
  steps = 0;
  while (!exp_halt && !exp_fault && steps < MAX_INSTR) begin
    steps++;
    if (!model_read(pc, w0)) break;          // word 0, opcode and register
    if (!model_read(pc + 1'b1, w1)) break;   // word 1, operand
    pc = pc + 2'd2;
    ri = w0[2:0];
    case (w0[15:8])
      op_jmp:       pc = w1[`CPU_ADDR_W-1:0];
      op_num2reg:   model_regs[ri] = w1;
      op_reg_plus:  model_regs[ri] = model_regs[ri] + w1;  // 16-bit wrap
      op_reg_minus: model_regs[ri] = model_regs[ri] - w1;
      op_ram2reg: begin
        if (model_read(w1[`CPU_ADDR_W-1:0], rd)) model_regs[ri] = rd;
      end
      op_reg2ram:   model_write(w1[`CPU_ADDR_W-1:0], model_regs[ri]);
      op_exit:      exp_halt = 1'b1;
      default: ;                                             // no-op
    endcase
  end
endtask

`endif

// File: tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module tb_cpu;
  import isa_pkg::*;

  localparam int RUNS        = 4;
  localparam int MAX_INSTR   = 40;                          // a program has 32 slots
  localparam int CYC_PER_INS = 60;
  localparam int CYCLE_LIMIT = RUNS * MAX_INSTR * CYC_PER_INS;
  localparam int MEM_WORDS   = 1 << `CPU_ADDR_W;
  localparam int LP_W        = `CPU_ADDR_W - `CPU_PAGE_BITS;
  localparam int SLOTS       = (1 << `CPU_PAGE_BITS) / 2;   // instructions in page 0
  localparam int PAGE_SPREAD = 12;                          // data on logical pages 1..12
  localparam int IDLE_CYCLES = 20;                          // quiet bus after halt

  logic                   clka;
  logic                   rst;
  logic                   mem_rd;
  logic                   mem_wr;
  logic [`CPU_ADDR_W-1:0] mem_addr;
  logic [`CPU_WORD_W-1:0] mem_wdata;
  logic [`CPU_WORD_W-1:0] mem_rdata;
  logic                   halted;
  logic                   fault;

  logic [`CPU_WORD_W-1:0] mem [MEM_WORDS];  // physical memory behind the port
  logic [31:0]            lcg_state;
  int                     cycle_count;
  int                     mismatch_count;
  int                     other_count;
  bit                     watching;         // bus compared against model queues

  `include "ref_model.svh"

  cpu_top i_dut (
    .clka      (clka),
    .rst       (rst),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .halted    (halted),
    .fault     (fault)
  );

  initial clka = 1'b0;
  always #2 clka = ~clka;  // 4 ns period

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`CPU_WORD_W-1:0] rand_word();
    logic [31:0] r;
    r = next_rand();
    return r[23:8];  // upper bits, low lcg bits are weak
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:16]) % n;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic watch_bus();
    if (mem_rd) begin
      if (exp_rd_addr.size() == 0) begin
        other_count++;
        $display("at %0t ns the core read address %h, the model has no read left", $time,
                 mem_addr);
      end else begin
        check("mem_addr on read", mem_addr, exp_rd_addr.pop_front());
      end
    end
    if (mem_wr) begin
      if (exp_wr_addr.size() == 0) begin
        other_count++;
        $display("at %0t ns the core wrote address %h, the model has no write left", $time,
                 mem_addr);
      end else begin
        check("mem_addr on write", mem_addr, exp_wr_addr.pop_front());
        check("mem_wdata", mem_wdata, exp_wr_data.pop_front());
      end
    end
  endtask

  // one clock, memory port served, outputs seen before the edge updates them
  task automatic tick();
    @(posedge clka);
    cycle_count++;
    if (watching) watch_bus();
    if (mem_rd) mem_rdata <= mem[mem_addr];  // data the cycle after mem_rd
    if (mem_wr) mem[mem_addr] = mem_wdata;
  endtask

  task automatic build_program();
    logic [7:0]             op;
    logic [`CPU_WORD_W-1:0] operand;
    logic [`CPU_WORD_W-1:0] rw;
    logic [LP_W-1:0]        lp;
    int                     kind;
    int                     target;
    for (int a = 0; a < MEM_WORDS; a++) mem[a] = rand_word();
    for (int slot = 0; slot < SLOTS - 1; slot++) begin
      kind    = pick(16);
      operand = rand_word();
      lp      = LP_W'(1 + pick(PAGE_SPREAD));
      target  = slot + 1 + pick(SLOTS - 1 - slot);  // forward only, so the program ends
      case (kind)
        0, 1, 2:  op = op_ram2reg;
        3, 4, 5:  op = op_reg2ram;
        6, 7, 14: op = op_num2reg;
        8, 9:     op = op_reg_plus;
        10, 11:   op = op_reg_minus;
        12:       op = op_jmp;
        13:       op = 8'd9;                         // not an opcode of this core
        default:  op = (pick(4) == 0) ? op_exit : op_reg2ram;
      endcase
      if (op == op_ram2reg || op == op_reg2ram) begin
        operand[`CPU_ADDR_W-1:`CPU_PAGE_BITS] = lp;  // data page, upper bits ignored
      end
      if (op == op_jmp) begin
        operand[`CPU_ADDR_W-1:0] = {{LP_W{1'b0}}, target[`CPU_PAGE_BITS-2:0], 1'b0};
      end
      rw                = rand_word();
      mem[2 * slot]     = {op, rw[7:0]};           // reg field, low 3 bits used
      mem[2 * slot + 1] = operand;
    end
    rw                     = rand_word();
    mem[2 * (SLOTS - 1)]   = {op_exit, rw[7:0]};   // last slot always stops
  endtask

  task automatic run_one(input int run);
    build_program();
    run_model();
    rst <= 1'b0;
    repeat (3) tick();
    rst <= 1'b1;
    tick();
    check("mem_rd after reset", mem_rd, 0);
    check("mem_wr after reset", mem_wr, 0);
    check("halted after reset", halted, 0);
    check("fault after reset", fault, 0);
    watching = 1'b1;
    while (!halted && !fault) tick();
    repeat (IDLE_CYCLES) tick();                   // no traffic may follow
    watching = 1'b0;
    check("halted", halted, exp_halt);
    check("fault", fault, exp_fault);
    if (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0) begin
      other_count++;
      $display("run %0d: %0d reads and %0d writes of the model never came on the bus", run,
               exp_rd_addr.size(), exp_wr_addr.size());
    end
  endtask

  // stops a hung run
  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst            <= 1'b0;
    mem_rdata      <= '0;
    lcg_state      = 32'hcb4a_644c;
    cycle_count    = 0;
    mismatch_count = 0;
    other_count    = 0;
    watching       = 1'b0;
    for (int run = 0; run < RUNS; run++) run_one(run);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
